/* files.f */
+incdir+include
hw/irq_csr_pkg.sv
hw/irq_xfer_pkg.sv
hw/irq_access_if.sv
hw/irq_csr_decode.sv
hw/irq_transfer_fsm.sv
hw/irq_reg_file.sv
hw/irq_result.sv
hw/irq_ctl_top.sv
test/irq_ctl_chk.sv
test/irq_ctl_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= irq_ctl_tb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing -Wall

SRCS := $(shell grep -v '^+' files.f) include/irq_defs.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) files.f
	$(VERILATOR) $(VFLAGS) -f files.f --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@! grep -q "Testbench failed" $(LOG)
	@grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* test/irq_ctl_tb.sv */
// interrupt controller testbench
// random and directed CSR traffic and transfers, checked against a reference model

`include "irq_defs.svh"

module irq_ctl_tb;
    import irq_csr_pkg::*;
    import irq_xfer_pkg::*;

    localparam int W = `IRQ_DATA_W;

    logic clk;
    logic reset;
    logic simt_read_enable, simt_write_enable;
    logic [`IRQ_ADDR_W-1:0] simt_read_addr, simt_write_addr;
    lane_data_t simt_write_data, simt_read_data;
    logic [`IRQ_NUM_LANES-1:0] simt_write_tmask;
    logic [`IRQ_NW_W-1:0] simt_write_wid;
    logic scalar_read_enable, scalar_write_enable;
    logic [`IRQ_ADDR_W-1:0] scalar_read_addr, scalar_write_addr;
    lane_data_t scalar_write_data, scalar_read_data;
    logic [`IRQ_NUM_LANES-1:0] scalar_write_tmask;
    logic [`IRQ_NW_W-1:0] scalar_write_wid;
    logic pipeline_drained, thread_found, isr_done;
    logic [`IRQ_NUM_LANES-1:0] cur_thread_mask, load_tmask;
    logic [`IRQ_NUM_WARPS-1:0] cur_active_warps, load_wmask, warp_hits;
    logic [W-1:0] cur_pc, load_pc, ret_pc_w0, ret_pc, ras;
    logic [W-1:0] overload_jal, ret_handler_addr, scalar_ipc;
    logic ret_pc_w0_commit, ret_pc_commit, ras_write;
    logic [`IRQ_NW_W-1:0] xfer_wid;
    logic [`IRQ_NT_W-1:0] xfer_tid;
    xfer_state_e state;

    integer seed = 32'hbee787e4;

    irq_regs_t   m;        // model registers
    xfer_state_e m_state;

    irq_ctl_top dut0 (.*);

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ********************
    // compare tasks
    task automatic stop_on_error();
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_lanes(input string name, input lane_data_t got, input lane_data_t exp);
        if (got !== exp)
        begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_word(input string name, input logic [W-1:0] got,
                              input logic [W-1:0] exp);
        if (got !== exp)
        begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_state(input string name, input xfer_state_e got,
                               input xfer_state_e exp);
        if (got !== exp)
        begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            stop_on_error();
        end
    endtask

    // ********************
    // reference model
    function automatic logic [W-1:0] model_read(input logic [`IRQ_ADDR_W-1:0] addr);
        case (addr)
            `IRQ_ADDR_S2V:   return m.s2v;
            `IRQ_ADDR_V2S:   return m.v2s;
            `IRQ_ADDR_TID:   return m.tid;
            `IRQ_ADDR_IPC:   return m.ipc;
            `IRQ_ADDR_IRQ:   return m.irq;
            `IRQ_ADDR_ERR:   return m.err;
            `IRQ_ADDR_JALOL: return m.jalol;
            `IRQ_ADDR_RHA:   return m.rha;
            `IRQ_ADDR_RAV:   return m.rav;
            `IRQ_ADDR_RAS:   return m.ras;
            `IRQ_ADDR_RAVW0: return m.ravw0;
            default:         return '0;
        endcase
    endfunction

    // first lane with its tmask bit set
    function automatic logic [W-1:0] pick_lane(input lane_data_t d,
                                               input logic [`IRQ_NUM_LANES-1:0] tm);
        for (int i = 0; i < `IRQ_NUM_LANES; i++)
        begin
            if (tm[i])
                return d[i];
        end
        return d[0];
    endfunction

    function automatic irq_regs_t model_write(input irq_regs_t r,
                                              input logic [`IRQ_ADDR_W-1:0] addr,
                                              input logic [W-1:0] v, input logic from_simt,
                                              input logic [`IRQ_NW_W-1:0] wid);
        case (addr)
            `IRQ_ADDR_S2V:   r.s2v = v;
            `IRQ_ADDR_V2S:   r.v2s = v;
            `IRQ_ADDR_TID:   r.tid = v;
            `IRQ_ADDR_IPC:   r.ipc = v;
            `IRQ_ADDR_IRQ:   r.irq = v;
            `IRQ_ADDR_ERR:   r.err = v;
            `IRQ_ADDR_JALOL: r.jalol = from_simt ? (m.jalol | (v << wid)) : v;
            `IRQ_ADDR_RHA:   r.rha = v;
            `IRQ_ADDR_RAV:   r.rav = v;
            `IRQ_ADDR_RAS:   r.ras = v;
            `IRQ_ADDR_RAVW0: r.ravw0 = v;
            default:         r = r;
        endcase
        return r;
    endfunction

    task automatic model_step();
        irq_regs_t   n;
        xfer_state_e ns;
        logic        ack, bad, cap, hold;
        n = m;
        ns = m_state;
        ack = 1'b0;
        bad = 1'b0;
        cap = 1'b0;
        hold = 1'b0;
        case (m_state)
            XFER_IDLE:
            begin
                ack = (m.s2v == 0);
                if (m.s2v == 1 && m.err == 0 && m.v2s == 0)
                    ns = XFER_WAIT;
            end
            XFER_WAIT:
            begin
                if (pipeline_drained && thread_found)
                begin
                    cap = 1'b1;
                    ns = XFER_PC_SWAP;
                end
                else if (pipeline_drained)
                begin
                    bad = 1'b1;
                    ns = XFER_IDLE;
                end
            end
            XFER_PC_SWAP:  ns = XFER_WAIT_ISR;
            XFER_WAIT_ISR: ns = isr_done ? XFER_REVERT_WARP : XFER_WAIT_ISR;
            default:
            begin
                hold = 1'b1;
                ack = (m.s2v == 0);
                if (ack)
                    ns = XFER_IDLE;
            end
        endcase
        if (simt_write_enable)
            n = model_write(n, simt_write_addr, pick_lane(simt_write_data, simt_write_tmask),
                            1'b1, simt_write_wid);
        if (scalar_write_enable)
            n = model_write(n, scalar_write_addr,
                            pick_lane(scalar_write_data, scalar_write_tmask), 1'b0, 2'd0);
        if (ack)
        begin
            n.v2s = 0;
            n.err = 0;
        end
        if (bad)
        begin
            n.v2s = 1;
            n.err = 1;
        end
        if (cap)
        begin
            n.tmask = W'(cur_thread_mask);
            n.wmask = W'(cur_active_warps);
            n.ipc = cur_pc;
        end
        if (hold && !ack)
            n.v2s = 1;
        if (ret_pc_w0_commit)
            n.ravw0 = ret_pc_w0;
        if (ret_pc_commit)
            n.rav = ret_pc;
        n.jalol = n.jalol & ~W'(warp_hits);
        if (ras_write)
            n.ras = ras;
        m = n;
        m_state = ns;
    endtask

    task automatic check_outputs();
        lane_data_t exp_simt, exp_scalar;
        exp_simt = '0;
        exp_scalar = '0;
        if (simt_read_enable)
            exp_simt = {`IRQ_NUM_LANES{model_read(simt_write_enable ? simt_write_addr
                                                                    : simt_read_addr)}};
        if (scalar_read_enable)
            exp_scalar = {`IRQ_NUM_LANES{model_read(scalar_write_enable ? scalar_write_addr
                                                                        : scalar_read_addr)}};
        check_lanes("simt_read_data", simt_read_data, exp_simt);
        check_lanes("scalar_read_data", scalar_read_data, exp_scalar);
        check_state("state", state, m_state);
        check_word("load_pc", load_pc, (m_state == XFER_REVERT_WARP) ? m.ipc : m.irq);
        check_word("overload_jal", overload_jal, m.jalol);
        check_word("ret_handler_addr", ret_handler_addr, m.rha);
        check_word("scalar_ipc", scalar_ipc, m.ipc);
        check_word("xfer_wid", W'(xfer_wid), W'(m.tid[3:2]));
        check_word("xfer_tid", W'(xfer_tid), W'(m.tid[1:0]));
        check_word("load_tmask", W'(load_tmask), W'(m.tmask[`IRQ_NUM_LANES-1:0]));
        check_word("load_wmask", W'(load_wmask), W'(m.wmask[`IRQ_NUM_WARPS-1:0]));
    endtask

    // inputs are already set on the falling edge
    task automatic cycle();
        #10;
        check_outputs();
        @(posedge clk);
        model_step();
        @(negedge clk);
    endtask

    task automatic wait_state(input xfer_state_e target);
        int n;
        n = 0;
        while (state !== target)
        begin
            if (n == 40)
            begin
                $display("timeout waiting for FSM state %s", target.name());
                stop_on_error();
            end
            cycle();
            n++;
        end
    endtask

    // ********************
    // stimulus
    task automatic quiet_inputs();
        {simt_read_enable, simt_write_enable, scalar_read_enable, scalar_write_enable} = '0;
        {simt_read_addr, simt_write_addr, scalar_read_addr, scalar_write_addr} = '0;
        {simt_write_data, scalar_write_data, simt_write_tmask, scalar_write_tmask} = '0;
        {simt_write_wid, scalar_write_wid, pipeline_drained, thread_found, isr_done} = '0;
        {cur_thread_mask, cur_active_warps, cur_pc, warp_hits} = '0;
        {ret_pc_w0_commit, ret_pc_w0, ret_pc_commit, ret_pc, ras_write, ras} = '0;
    endtask

    function automatic logic [`IRQ_ADDR_W-1:0] rand_addr();
        logic [31:0] r;
        r = $random(seed);
        if (r[7:4] == 0)
            return r[27:16];  // mostly far outside the map
        return `IRQ_ADDR_S2V + `IRQ_ADDR_W'(r[15:8] % 14);
    endfunction

    function automatic lane_data_t rand_lanes();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    task automatic random_inputs();
        logic [31:0] r;
        r = $random(seed);
        {simt_read_enable, simt_write_enable, scalar_read_enable, scalar_write_enable} = r[3:0];
        simt_read_addr = rand_addr();
        simt_write_addr = rand_addr();
        scalar_read_addr = rand_addr();
        scalar_write_addr = r[4] ? simt_write_addr : rand_addr();  // collide often
        simt_write_data = rand_lanes();
        scalar_write_data = rand_lanes();
        {simt_write_tmask, scalar_write_tmask, simt_write_wid} = r[14:5];
        {pipeline_drained, thread_found, isr_done} = r[17:15];
        {cur_thread_mask, cur_active_warps} = r[25:18];
        warp_hits = r[29:26] & r[31:28];
        cur_pc = $random(seed);
        r = $random(seed);
        ret_pc_w0_commit = (r[1:0] == 0);
        ret_pc_commit = (r[3:2] == 0);
        ras_write = (r[5:4] == 0);
        ret_pc_w0 = $random(seed);
        ret_pc = $random(seed);
        ras = $random(seed);
    endtask

    task automatic scalar_write(input logic [`IRQ_ADDR_W-1:0] addr, input logic [W-1:0] v);
        scalar_write_enable = 1'b1;
        scalar_write_addr = addr;
        scalar_write_data = {`IRQ_NUM_LANES{v}};
        cycle();
        scalar_write_enable = 1'b0;
    endtask

    initial
    begin
        quiet_inputs();
        reset = 1'b1;
        m = '0;
        m_state = XFER_IDLE;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // random traffic on both ports with random transfer and commit inputs
        for (int i = 0; i < 3000; i++)
        begin
            random_inputs();
            cycle();
        end

        // full transfer
        quiet_inputs();
        scalar_write(`IRQ_ADDR_ERR, 0);
        scalar_write(`IRQ_ADDR_V2S, 0);
        scalar_write(`IRQ_ADDR_S2V, 0);
        wait_state(XFER_IDLE);
        scalar_write(`IRQ_ADDR_IRQ, 32'h0000_8000);
        scalar_write(`IRQ_ADDR_S2V, 1);
        wait_state(XFER_WAIT);
        {pipeline_drained, thread_found} = 2'b11;
        cur_thread_mask = 4'b0110;
        cur_active_warps = 4'b1001;
        cur_pc = 32'h0000_1234;
        wait_state(XFER_PC_SWAP);
        pipeline_drained = 1'b0;
        wait_state(XFER_WAIT_ISR);
        isr_done = 1'b1;
        wait_state(XFER_REVERT_WARP);
        isr_done = 1'b0;
        scalar_read_enable = 1'b1;
        scalar_read_addr = `IRQ_ADDR_V2S;
        cycle();
        cycle();
        scalar_write(`IRQ_ADDR_S2V, 0);
        wait_state(XFER_IDLE);
        cycle();

        // bad thread
        scalar_write(`IRQ_ADDR_S2V, 1);
        wait_state(XFER_WAIT);
        {pipeline_drained, thread_found} = 2'b10;
        wait_state(XFER_IDLE);
        pipeline_drained = 1'b0;
        scalar_read_addr = `IRQ_ADDR_ERR;
        cycle();
        scalar_write(`IRQ_ADDR_S2V, 0);
        cycle();
        cycle();

        // commit against a bus write to the same register
        ret_pc_commit = 1'b1;
        ret_pc = 32'hcafe_0001;
        scalar_read_addr = `IRQ_ADDR_RAV;
        scalar_write(`IRQ_ADDR_RAV, 32'h0bad_0bad);
        ret_pc_commit = 1'b0;
        cycle();

        $display("Testbench passed");
        $finish;
    end

endmodule

/* test/irq_ctl_chk.sv */
// interrupt controller assertions
// reset value of the jal overload and FSM exit rules

module irq_ctl_chk (
    input logic                      clk,
    input logic                      reset,
    input irq_xfer_pkg::xfer_state_e state,
    input logic [31:0]               overload_jal
);
    import irq_xfer_pkg::*;

    // registers clear on the first reset clock
    jal_clear_in_reset: assert property (@(posedge clk) reset |=> overload_jal == '0)
        else $error("overload_jal not cleared by reset");

    swap_then_isr: assert property (@(posedge clk) disable iff (reset)
        state == XFER_PC_SWAP |=> state == XFER_WAIT_ISR)
        else $error("pc_swap not followed by wait_isr");

    revert_exit: assert property (@(posedge clk) disable iff (reset)
        state == XFER_REVERT_WARP |=> state inside {XFER_REVERT_WARP, XFER_IDLE})
        else $error("revert_warp left toward a state other than idle");

endmodule

bind irq_ctl_top irq_ctl_chk chk0 (
    .clk(clk),
    .reset(reset),
    .state(state),
    .overload_jal(overload_jal)
);

/* hw/irq_ctl_top.sv */
// interrupt controller top level
// SIMT and scalar CSR ports, transfer FSM, register set and outputs

`include "irq_defs.svh"

module irq_ctl_top (
    input  logic                        clk,
    input  logic                        reset,
    // SIMT CSR port
    input  logic                        simt_read_enable,
    input  logic                        simt_write_enable,
    input  logic [`IRQ_ADDR_W-1:0]      simt_read_addr,
    input  logic [`IRQ_ADDR_W-1:0]      simt_write_addr,
    input  irq_csr_pkg::lane_data_t     simt_write_data,
    input  logic [`IRQ_NUM_LANES-1:0]   simt_write_tmask,
    input  logic [`IRQ_NW_W-1:0]        simt_write_wid,
    output irq_csr_pkg::lane_data_t     simt_read_data,
    // scalar CSR port
    input  logic                        scalar_read_enable,
    input  logic                        scalar_write_enable,
    input  logic [`IRQ_ADDR_W-1:0]      scalar_read_addr,
    input  logic [`IRQ_ADDR_W-1:0]      scalar_write_addr,
    input  irq_csr_pkg::lane_data_t     scalar_write_data,
    input  logic [`IRQ_NUM_LANES-1:0]   scalar_write_tmask,
    input  logic [`IRQ_NW_W-1:0]        scalar_write_wid,
    output irq_csr_pkg::lane_data_t     scalar_read_data,
    // thread transfer unit
    input  logic                        pipeline_drained,
    input  logic                        thread_found,
    input  logic                        isr_done,
    input  logic [`IRQ_NUM_LANES-1:0]   cur_thread_mask,
    input  logic [`IRQ_NUM_WARPS-1:0]   cur_active_warps,
    input  logic [`IRQ_DATA_W-1:0]      cur_pc,
    output irq_xfer_pkg::xfer_state_e   state,
    output logic [`IRQ_NW_W-1:0]        xfer_wid,
    output logic [`IRQ_NT_W-1:0]        xfer_tid,
    output logic [`IRQ_NUM_LANES-1:0]   load_tmask,
    output logic [`IRQ_NUM_WARPS-1:0]   load_wmask,
    output logic [`IRQ_DATA_W-1:0]      load_pc,
    // execute stages
    input  logic                        ret_pc_w0_commit,
    input  logic [`IRQ_DATA_W-1:0]      ret_pc_w0,
    input  logic                        ret_pc_commit,
    input  logic [`IRQ_DATA_W-1:0]      ret_pc,
    input  logic [`IRQ_NUM_WARPS-1:0]   warp_hits,
    input  logic                        ras_write,
    input  logic [`IRQ_DATA_W-1:0]      ras,
    output logic [`IRQ_DATA_W-1:0]      overload_jal,
    output logic [`IRQ_DATA_W-1:0]      ret_handler_addr,
    output logic [`IRQ_DATA_W-1:0]      scalar_ipc
);
    import irq_csr_pkg::*;
    import irq_xfer_pkg::*;

    irq_regs_t    regs;
    xfer_events_t events;

    irq_access_if simt_acc ();
    irq_access_if scalar_acc ();

    irq_csr_decode simt_dec (
        .clk(clk), .reset(reset),
        .read_enable(simt_read_enable), .write_enable(simt_write_enable),
        .read_addr(simt_read_addr), .write_addr(simt_write_addr),
        .write_data(simt_write_data), .write_tmask(simt_write_tmask),
        .write_wid(simt_write_wid), .acc(simt_acc.src)
    );

    irq_csr_decode scalar_dec (
        .clk(clk), .reset(reset),
        .read_enable(scalar_read_enable), .write_enable(scalar_write_enable),
        .read_addr(scalar_read_addr), .write_addr(scalar_write_addr),
        .write_data(scalar_write_data), .write_tmask(scalar_write_tmask),
        .write_wid(scalar_write_wid), .acc(scalar_acc.src)
    );

    irq_transfer_fsm fsm (
        .clk(clk), .reset(reset), .regs(regs),
        .pipeline_drained(pipeline_drained), .thread_found(thread_found),
        .isr_done(isr_done), .state(state), .events(events)
    );

    irq_reg_file reg_file (
        .clk(clk), .reset(reset),
        .simt_acc(simt_acc.dst), .scalar_acc(scalar_acc.dst), .events(events),
        .cur_thread_mask(cur_thread_mask), .cur_active_warps(cur_active_warps),
        .cur_pc(cur_pc), .ret_pc_w0_commit(ret_pc_w0_commit), .ret_pc_w0(ret_pc_w0),
        .ret_pc_commit(ret_pc_commit), .ret_pc(ret_pc), .warp_hits(warp_hits),
        .ras_write(ras_write), .ras(ras), .regs(regs)
    );

    irq_result result (
        .regs(regs), .state(state),
        .simt_acc(simt_acc.mon), .scalar_acc(scalar_acc.mon),
        .simt_read_data(simt_read_data), .scalar_read_data(scalar_read_data),
        .xfer_wid(xfer_wid), .xfer_tid(xfer_tid),
        .load_tmask(load_tmask), .load_wmask(load_wmask), .load_pc(load_pc),
        .overload_jal(overload_jal), .ret_handler_addr(ret_handler_addr),
        .scalar_ipc(scalar_ipc)
    );

endmodule

/* hw/irq_result.sv */
// result stage
// read data for both ports and the transfer and execute outputs

`include "irq_defs.svh"

module irq_result (
    input  irq_csr_pkg::irq_regs_t       regs,
    input  irq_xfer_pkg::xfer_state_e    state,
    irq_access_if.mon                    simt_acc,
    irq_access_if.mon                    scalar_acc,
    output irq_csr_pkg::lane_data_t      simt_read_data,
    output irq_csr_pkg::lane_data_t      scalar_read_data,
    output logic [`IRQ_NW_W-1:0]         xfer_wid,
    output logic [`IRQ_NT_W-1:0]         xfer_tid,
    output logic [`IRQ_NUM_LANES-1:0]    load_tmask,
    output logic [`IRQ_NUM_WARPS-1:0]    load_wmask,
    output logic [`IRQ_DATA_W-1:0]       load_pc,
    output logic [`IRQ_DATA_W-1:0]       overload_jal,
    output logic [`IRQ_DATA_W-1:0]       ret_handler_addr,
    output logic [`IRQ_DATA_W-1:0]       scalar_ipc
);
    import irq_csr_pkg::*;
    import irq_xfer_pkg::*;

    function automatic logic [`IRQ_DATA_W-1:0] read_word(input irq_regs_t r,
                                                         input csr_reg_e sel);
        case (sel)
            CSR_S2V:   read_word = r.s2v;
            CSR_V2S:   read_word = r.v2s;
            CSR_TID:   read_word = r.tid;
            CSR_IPC:   read_word = r.ipc;
            CSR_IRQ:   read_word = r.irq;
            CSR_ERR:   read_word = r.err;
            CSR_JALOL: read_word = r.jalol;
            CSR_RHA:   read_word = r.rha;
            CSR_RAV:   read_word = r.rav;
            CSR_RAS:   read_word = r.ras;
            CSR_RAVW0: read_word = r.ravw0;
            default:   read_word = '0;  // unmapped
        endcase
    endfunction

    // same word on every lane
    assign simt_read_data   = simt_acc.read_enable ?
                              {`IRQ_NUM_LANES{read_word(regs, simt_acc.reg_sel)}} : '0;
    assign scalar_read_data = scalar_acc.read_enable ?
                              {`IRQ_NUM_LANES{read_word(regs, scalar_acc.reg_sel)}} : '0;

    // ********************
    // to thread transfer unit
    assign xfer_wid   = regs.tid[`IRQ_NT_W+`IRQ_NW_W-1:`IRQ_NT_W];
    assign xfer_tid   = regs.tid[`IRQ_NT_W-1:0];
    assign load_tmask = regs.tmask[`IRQ_NUM_LANES-1:0];
    assign load_wmask = regs.wmask[`IRQ_NUM_WARPS-1:0];
    assign load_pc    = (state == XFER_REVERT_WARP) ? regs.ipc : regs.irq;

    // to execute stages
    assign overload_jal     = regs.jalol;
    assign ret_handler_addr = regs.rha;  // link value for overloaded jal
    assign scalar_ipc       = regs.ipc;

endmodule

/* hw/irq_reg_file.sv */
// interrupt controller register set
// applies port writes, FSM events and execute unit commits in priority order

`include "irq_defs.svh"

module irq_reg_file (
    input  logic                        clk,
    input  logic                        reset,
    irq_access_if.dst                   simt_acc,
    irq_access_if.dst                   scalar_acc,
    input  irq_xfer_pkg::xfer_events_t  events,
    input  logic [`IRQ_NUM_LANES-1:0]   cur_thread_mask,
    input  logic [`IRQ_NUM_WARPS-1:0]   cur_active_warps,
    input  logic [`IRQ_DATA_W-1:0]      cur_pc,
    input  logic                        ret_pc_w0_commit,
    input  logic [`IRQ_DATA_W-1:0]      ret_pc_w0,
    input  logic                        ret_pc_commit,
    input  logic [`IRQ_DATA_W-1:0]      ret_pc,
    input  logic [`IRQ_NUM_WARPS-1:0]   warp_hits,
    input  logic                        ras_write,
    input  logic [`IRQ_DATA_W-1:0]      ras,
    output irq_csr_pkg::irq_regs_t      regs
);
    import irq_csr_pkg::*;

    localparam int W = `IRQ_DATA_W;

    irq_regs_t       nxt;
    logic [W-1:0]    simt_jal;

    // jal_value is what JALOL takes, the rule differs per port
    function automatic irq_regs_t apply_write(input irq_regs_t cur, input csr_reg_e sel,
                                              input logic [W-1:0] value,
                                              input logic [W-1:0] jal_value);
        irq_regs_t r;
        r = cur;
        case (sel)
            CSR_S2V:   r.s2v   = value;
            CSR_V2S:   r.v2s   = value;
            CSR_TID:   r.tid   = value;
            CSR_IPC:   r.ipc   = value;
            CSR_IRQ:   r.irq   = value;
            CSR_ERR:   r.err   = value;
            CSR_JALOL: r.jalol = jal_value;
            CSR_RHA:   r.rha   = value;
            CSR_RAV:   r.rav   = value;
            CSR_RAS:   r.ras   = value;
            CSR_RAVW0: r.ravw0 = value;
            default:   r = cur;
        endcase
        return r;
    endfunction

    // SIMT sets one bit per warp
    assign simt_jal = regs.jalol | (simt_acc.write_value << simt_acc.write_wid);

    always_comb
    begin
        nxt = regs;

        // ********************
        // bus writes, scalar after SIMT
        if (simt_acc.write_enable)
            nxt = apply_write(nxt, simt_acc.reg_sel, simt_acc.write_value, simt_jal);
        if (scalar_acc.write_enable)
            nxt = apply_write(nxt, scalar_acc.reg_sel, scalar_acc.write_value,
                              scalar_acc.write_value);

        // ********************
        // FSM events
        if (events.ack_clear)
        begin
            nxt.v2s = '0;
            nxt.err = '0;
        end
        if (events.bad_thread)
        begin
            nxt.err = W'(1);
            nxt.v2s = W'(1);
        end
        if (events.capture)
        begin
            nxt.tmask = W'(cur_thread_mask);
            nxt.wmask = W'(cur_active_warps);
            nxt.ipc   = cur_pc;
        end
        if (events.revert_hold && !events.ack_clear)
            nxt.v2s = W'(1);

        // ********************
        // execute unit commits
        if (ret_pc_w0_commit)
            nxt.ravw0 = ret_pc_w0;  // warp 0 return to kernel scheduler
        if (ret_pc_commit)
            nxt.rav = ret_pc;
        nxt.jalol = nxt.jalol & ~W'(warp_hits);  // warps already in the kernel
        if (ras_write)
            nxt.ras = ras;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            regs <= '0;
        else
            regs <= nxt;
    end

endmodule

/* hw/irq_transfer_fsm.sv */
// thread transfer FSM
// walks idle, wait, pc_swap, wait_isr, revert_warp and raises register events

`include "irq_defs.svh"

module irq_transfer_fsm (
    input  logic                      clk,
    input  logic                      reset,
    input  irq_csr_pkg::irq_regs_t    regs,
    input  logic                      pipeline_drained,
    input  logic                      thread_found,
    input  logic                      isr_done,
    output irq_xfer_pkg::xfer_state_e state,
    output irq_xfer_pkg::xfer_events_t events
);
    import irq_xfer_pkg::*;

    xfer_state_e next_state;

    always_ff @(posedge clk)
    begin
        if (reset)
            state <= XFER_IDLE;
        else
            state <= next_state;
    end

    // ********************
    // next state and event strobes
    always_comb
    begin
        next_state = state;
        events     = '0;
        case (state)
            XFER_IDLE:
            begin
                if (regs.s2v == '0)
                    events.ack_clear = 1'b1;  // scalar acknowledged
                if (regs.s2v == 1 && regs.err == '0 && regs.v2s == '0)
                    next_state = XFER_WAIT;
            end
            XFER_WAIT:
            begin
                if (pipeline_drained)
                begin
                    if (thread_found)
                    begin
                        events.capture = 1'b1;
                        next_state     = XFER_PC_SWAP;
                    end
                    else
                    begin
                        events.bad_thread = 1'b1;
                        next_state        = XFER_IDLE;
                    end
                end
            end
            XFER_PC_SWAP:  next_state = XFER_WAIT_ISR;
            XFER_WAIT_ISR:
            begin
                if (isr_done)
                    next_state = XFER_REVERT_WARP;
            end
            XFER_REVERT_WARP:
            begin
                events.revert_hold = 1'b1;
                if (regs.s2v == '0)  // scalar done loading thread
                begin
                    events.ack_clear = 1'b1;
                    next_state       = XFER_IDLE;
                end
            end
            default:       next_state = XFER_IDLE;
        endcase
    end

endmodule

/* hw/irq_csr_decode.sv */
// CSR port decode
// maps the bus address to a register and picks the written lane

`include "irq_defs.svh"

module irq_csr_decode (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     read_enable,
    input  logic                     write_enable,
    input  logic [`IRQ_ADDR_W-1:0]   read_addr,
    input  logic [`IRQ_ADDR_W-1:0]   write_addr,
    input  irq_csr_pkg::lane_data_t  write_data,
    input  logic [`IRQ_NUM_LANES-1:0] write_tmask,
    input  logic [`IRQ_NW_W-1:0]     write_wid,
    irq_access_if.src                acc
);
    import irq_csr_pkg::*;

    logic [`IRQ_ADDR_W-1:0] addr;
    logic [`IRQ_NT_W-1:0]   lane;

    assign addr = write_enable ? write_addr : read_addr;

    always_comb
    begin
        case (addr)
            `IRQ_ADDR_S2V:   acc.reg_sel = CSR_S2V;
            `IRQ_ADDR_V2S:   acc.reg_sel = CSR_V2S;
            `IRQ_ADDR_TID:   acc.reg_sel = CSR_TID;
            `IRQ_ADDR_IPC:   acc.reg_sel = CSR_IPC;
            `IRQ_ADDR_IRQ:   acc.reg_sel = CSR_IRQ;
            `IRQ_ADDR_ERR:   acc.reg_sel = CSR_ERR;
            `IRQ_ADDR_JALOL: acc.reg_sel = CSR_JALOL;
            `IRQ_ADDR_RHA:   acc.reg_sel = CSR_RHA;
            `IRQ_ADDR_RAV:   acc.reg_sel = CSR_RAV;
            `IRQ_ADDR_RAS:   acc.reg_sel = CSR_RAS;
            `IRQ_ADDR_RAVW0: acc.reg_sel = CSR_RAVW0;
            default:         acc.reg_sel = CSR_NONE;
        endcase
    end

    // lowest set tmask bit wins, lane 0 when none set
    always_comb
    begin
        lane = '0;
        for (int i = `IRQ_NUM_LANES - 1; i >= 0; i--)
        begin
            if (write_tmask[i])
                lane = `IRQ_NT_W'(i);
        end
    end

    assign acc.read_enable  = read_enable;
    assign acc.write_enable = write_enable;
    assign acc.write_value  = write_data[lane];
    assign acc.write_wid    = write_wid;

endmodule

/* hw/irq_access_if.sv */
// one decoded CSR access from a core port
// decoder drives it, register file and result stage consume it

`include "irq_defs.svh"

interface irq_access_if;
    import irq_csr_pkg::*;

    csr_reg_e               reg_sel;
    logic                   read_enable;
    logic                   write_enable;
    logic [`IRQ_DATA_W-1:0] write_value;  // selected lane
    logic [`IRQ_NW_W-1:0]   write_wid;

    modport src (output reg_sel, output read_enable, output write_enable,
                 output write_value, output write_wid);

    modport dst (input reg_sel, input read_enable, input write_enable,
                 input write_value, input write_wid);

    modport mon (input reg_sel, input read_enable);

endinterface

/* hw/irq_xfer_pkg.sv */
// transfer side types of the interrupt controller
// FSM state and the event strobes it raises

`include "irq_defs.svh"

package irq_xfer_pkg;

    typedef enum logic [2:0] {
        XFER_IDLE,
        XFER_WAIT,
        XFER_PC_SWAP,
        XFER_WAIT_ISR,
        XFER_REVERT_WARP
    } xfer_state_e;

    typedef struct packed {
        logic bad_thread;   // drained with no thread found
        logic capture;      // latch tmask, wmask and pc
        logic revert_hold;  // let scalar core load thread
        logic ack_clear;    // clear V2S and ERR
    } xfer_events_t;

endpackage

/* hw/irq_csr_pkg.sv */
// CSR side types of the interrupt controller
// register index, lane data and the register set

`include "irq_defs.svh"

package irq_csr_pkg;

    // decoded register, CSR_NONE for unmapped addresses
    typedef enum logic [3:0] {
        CSR_NONE,
        CSR_S2V,
        CSR_V2S,
        CSR_TID,
        CSR_IPC,
        CSR_IRQ,
        CSR_ERR,
        CSR_JALOL,
        CSR_RHA,
        CSR_RAV,
        CSR_RAS,
        CSR_RAVW0
    } csr_reg_e;

    typedef logic [`IRQ_NUM_LANES-1:0][`IRQ_DATA_W-1:0] lane_data_t;

    typedef struct packed {
        logic [`IRQ_DATA_W-1:0] s2v;
        logic [`IRQ_DATA_W-1:0] v2s;
        logic [`IRQ_DATA_W-1:0] tid;
        logic [`IRQ_DATA_W-1:0] ipc;
        logic [`IRQ_DATA_W-1:0] irq;
        logic [`IRQ_DATA_W-1:0] err;
        logic [`IRQ_DATA_W-1:0] jalol;
        logic [`IRQ_DATA_W-1:0] rha;
        logic [`IRQ_DATA_W-1:0] rav;
        logic [`IRQ_DATA_W-1:0] ras;
        logic [`IRQ_DATA_W-1:0] ravw0;
        logic [`IRQ_DATA_W-1:0] tmask;  // no address, captured from transfer unit
        logic [`IRQ_DATA_W-1:0] wmask;
    } irq_regs_t;

endpackage

/* include/irq_defs.svh */
// interrupt controller parameters
// widths, lane and warp counts and the CSR address map

`ifndef IRQ_DEFS_SVH
`define IRQ_DEFS_SVH

// ********************
// sizes
`define IRQ_DATA_W      32
`define IRQ_ADDR_W      12
`define IRQ_NUM_LANES   4
`define IRQ_NUM_WARPS   4
`define IRQ_NT_W        2  // thread id width
`define IRQ_NW_W        2  // warp id width

// ********************
// CSR addresses
`define IRQ_ADDR_S2V    12'h7c0  // scalar to SIMT request
`define IRQ_ADDR_V2S    12'h7c1  // SIMT to scalar response
`define IRQ_ADDR_TID    12'h7c2
`define IRQ_ADDR_IPC    12'h7c3
`define IRQ_ADDR_IRQ    12'h7c4  // handler pc
`define IRQ_ADDR_ERR    12'h7c5
`define IRQ_ADDR_JALOL  12'h7c6  // jal overload, one bit per warp
`define IRQ_ADDR_RHA    12'h7c7
`define IRQ_ADDR_RAV    12'h7c8
`define IRQ_ADDR_RAS    12'h7c9
`define IRQ_ADDR_RAVW0  12'h7ca

`endif
